//--- verilog/axis_source_defines.svh
`ifndef AXIS_SOURCE_DEFINES_SVH
`define AXIS_SOURCE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Stream geometry
// ~~~~~~~~~~~~~~~~~~~~

// TDATA width in bits. Must be a multiple of 16 so it splits into two halves.
`define STREAM_TDATA_WIDTH 32

// ~~~~~~~~~~~~~~~~~~~~
// Burst pacing
// ~~~~~~~~~~~~~~~~~~~~

// Idle cycles counted before every burst.
`define STREAM_START_COUNT 32

// Beats per burst. The last one carries TLAST.
`define BURST_WORDS 8

`endif

//--- verilog/axis_source_pkg.sv
`include "axis_source_defines.svh"

package axis_source_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Stream beat
  // ~~~~~~~~~~~~~~~~~~~~

  // One AXI-Stream beat as it leaves the emitter.
  typedef struct packed {
    logic [`STREAM_TDATA_WIDTH-1:0]   tdata;
    logic [`STREAM_TDATA_WIDTH/8-1:0] tstrb;
    logic                             tlast;
  } axis_beat_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Sequencer states
  // ~~~~~~~~~~~~~~~~~~~~

  // The idle state waits for enable, the wait state counts the start delay
  // and the send state lasts until the emitter reports the burst done.
  typedef enum logic [1:0] {
    seq_idle = 2'd0,
    seq_wait = 2'd1,
    seq_send = 2'd2
  } seq_state_t;

endpackage

//--- verilog/burst_sequencer.sv
`timescale 1ns/1ps
`include "axis_source_defines.svh"

module burst_sequencer (
  input  logic                        M_AXIS_ACLK,
  input  logic                        M_AXIS_ARESETN,
  input  logic                        enable,
  input  logic                        burst_done,
  output logic                        burst_start,
  output axis_source_pkg::seq_state_t state
);

  import axis_source_pkg::*;

  // One spare bit keeps the width sane for very short delays.
  localparam int CNT_W = $clog2(`STREAM_START_COUNT + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`STREAM_START_COUNT - 1);

  logic [CNT_W-1:0] delay_cnt;
  logic             delay_done;

  assign delay_done = (delay_cnt == CNT_LAST);

  // ~~~~~~~~~~~~~~~~~~~~
  // Burst controller
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state       <= seq_idle;
      delay_cnt   <= '0;
      burst_start <= 1'b0;
    end else begin
      burst_start <= 1'b0;
      case (state)
        seq_idle: begin
          delay_cnt <= '0;
          if (enable) begin
            state <= seq_wait;
          end
        end
        seq_wait: begin
          if (!enable) begin
            // Losing enable restarts the full delay next time.
            state     <= seq_idle;
            delay_cnt <= '0;
          end else if (delay_done) begin
            state       <= seq_send;
            burst_start <= 1'b1;
            delay_cnt   <= '0;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        seq_send: begin
          // Enable is ignored here so a started burst always completes.
          if (burst_done) begin
            state <= seq_idle;
          end
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~

  // The emitter may only finish a burst that this controller ordered.
  a_done_in_send: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    burst_done |-> (state == seq_send)
  ) else $error("burst_done seen outside seq_send");

  // A start order is a single-cycle strobe.
  a_start_single: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    burst_start |=> !burst_start
  ) else $error("burst_start held for more than one cycle");

endmodule

//--- verilog/burst_emitter.sv
`timescale 1ns/1ps
`include "axis_source_defines.svh"

module burst_emitter (
  input  logic                        M_AXIS_ACLK,
  input  logic                        M_AXIS_ARESETN,
  input  logic                        burst_start,
  input  logic                        tready,
  output logic                        tvalid,
  output axis_source_pkg::axis_beat_t beat,
  output logic                        burst_done,
  output logic [15:0]                 frame_count
);

  import axis_source_pkg::*;

  localparam int HALF_W = `STREAM_TDATA_WIDTH / 2;
  localparam int PTR_W  = $clog2(`BURST_WORDS + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`BURST_WORDS - 1);

  logic [PTR_W-1:0]               ptr;
  logic [PTR_W-1:0]               ptr_next;
  logic [`STREAM_TDATA_WIDTH-1:0] tdata_q;
  logic [`STREAM_TDATA_WIDTH-1:0] pattern;
  logic                           tlast_q;
  logic                           out_free;
  logic                           load;
  logic                           finish;

  // ~~~~~~~~~~~~~~~~~~~~
  // Beat pointer and pattern
  // ~~~~~~~~~~~~~~~~~~~~

  // The output register may change only when it is empty or being taken.
  assign out_free = !tvalid || tready;

  // A new beat is loaded at burst start or when a non-final beat is accepted.
  assign load   = out_free && (burst_start || (tvalid && !tlast_q));
  assign finish = tvalid && tready && tlast_q;

  assign ptr_next = burst_start ? '0 : ptr + 1'b1;

  // Frame number on top, beat index plus one below.
  assign pattern = {HALF_W'(frame_count), HALF_W'(ptr_next) + HALF_W'(1)};

  always_ff @(posedge M_AXIS_ACLK) begin
    if (load) begin
      tdata_q <= pattern;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Output control
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      tvalid      <= 1'b0;
      tlast_q     <= 1'b0;
      ptr         <= '0;
      burst_done  <= 1'b0;
      frame_count <= '0;
    end else begin
      burst_done <= 1'b0;
      if (load) begin
        tvalid  <= 1'b1;
        ptr     <= ptr_next;
        tlast_q <= (ptr_next == PTR_LAST);
      end else if (finish) begin
        // Last beat accepted, so the frame is complete.
        tvalid      <= 1'b0;
        tlast_q     <= 1'b0;
        burst_done  <= 1'b1;
        frame_count <= frame_count + 16'd1;
      end
    end
  end

  // TSTRB never varies, every byte is a data byte.
  assign beat = '{
    tdata: tdata_q,
    tstrb: {(`STREAM_TDATA_WIDTH/8){1'b1}},
    tlast: tlast_q
  };

  // ~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~

  // A stalled beat must survive unchanged until the sink takes it.
  a_hold_stable: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (tvalid && !tready) |=> (tvalid && $stable(beat))
  ) else $error("beat changed while stalled");

  // TLAST goes out only with the final index of the burst.
  a_last_on_final: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    beat.tlast |-> (tvalid && beat.tdata[HALF_W-1:0] == HALF_W'(`BURST_WORDS))
  ) else $error("tlast on a beat that is not the last");

endmodule

//--- verilog/axis_pattern_source.sv
`timescale 1ns/1ps
`include "axis_source_defines.svh"

module axis_pattern_source (
  input  logic                             M_AXIS_ACLK,
  input  logic                             M_AXIS_ARESETN,
  input  logic                             enable,
  output logic                             M_AXIS_TVALID,
  output logic [`STREAM_TDATA_WIDTH-1:0]   M_AXIS_TDATA,
  output logic [`STREAM_TDATA_WIDTH/8-1:0] M_AXIS_TSTRB,
  output logic                             M_AXIS_TLAST,
  input  logic                             M_AXIS_TREADY,
  output logic [15:0]                      frame_count
);

  import axis_source_pkg::*;

  logic       burst_start;
  logic       burst_done;
  seq_state_t seq_state;
  axis_beat_t beat;

  // ~~~~~~~~~~~~~~~~~~~~
  // Blocks
  // ~~~~~~~~~~~~~~~~~~~~

  burst_sequencer burst_sequencer_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .enable         (enable),
    .burst_done     (burst_done),
    .burst_start    (burst_start),
    .state          (seq_state)
  );

  burst_emitter burst_emitter_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .burst_start    (burst_start),
    .tready         (M_AXIS_TREADY),
    .tvalid         (M_AXIS_TVALID),
    .beat           (beat),
    .burst_done     (burst_done),
    .frame_count    (frame_count)
  );

  // The beat struct fans out onto the AXI-Stream port.
  assign M_AXIS_TDATA = beat.tdata;
  assign M_AXIS_TSTRB = beat.tstrb;
  assign M_AXIS_TLAST = beat.tlast;

  // The stream is only ever active inside a burst the sequencer ordered.
  a_valid_in_send: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (seq_state != seq_send) |-> !M_AXIS_TVALID
  ) else $error("TVALID high outside seq_send");

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int CLK_PERIOD_NS = 4,
  parameter int RESET_CYCLES  = 16
) (
  output logic M_AXIS_ACLK,
  output logic M_AXIS_ARESETN
);

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #(CLK_PERIOD_NS / 2.0) M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  // Reset is released on a falling edge, away from the sampling edge.
  initial begin
    M_AXIS_ARESETN = 1'b0;
    repeat (RESET_CYCLES) @(posedge M_AXIS_ACLK);
    @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;
  end

endmodule

//--- testbench/tb_axis_pattern_source.sv
`timescale 1ns/1ps
`include "axis_source_defines.svh"

module tb_axis_pattern_source;

  localparam int CLK_PERIOD_NS   = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int HALF_W          = `STREAM_TDATA_WIDTH / 2;
  localparam int STRB_W          = `STREAM_TDATA_WIDTH / 8;
  localparam int N_ROWS          = 6;
  localparam int QUIET_CYCLES    = 3 * `STREAM_START_COUNT;
  localparam int FRAME_WORST     = `STREAM_START_COUNT + 4 + 50 * `BURST_WORDS + QUIET_CYCLES;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + QUIET_CYCLES + N_ROWS * FRAME_WORST + 100;

  // TREADY patterns used by the table.
  localparam int READY_ALWAYS    = 0;
  localparam int READY_ALTERNATE = 1;
  localparam int READY_RANDOM    = 2;

  logic                           M_AXIS_ACLK;
  logic                           M_AXIS_ARESETN;
  logic                           enable;
  logic                           M_AXIS_TVALID;
  logic [`STREAM_TDATA_WIDTH-1:0] M_AXIS_TDATA;
  logic [STRB_W-1:0]              M_AXIS_TSTRB;
  logic                           M_AXIS_TLAST;
  logic                           M_AXIS_TREADY;
  logic [15:0]                    frame_count;

  string row_name  [N_ROWS];
  int    row_mode  [N_ROWS];
  int    row_pct   [N_ROWS];
  bit    row_drop  [N_ROWS];
  int    row_beats [N_ROWS];

  int                             check_count;
  int                             error_count;
  int                             cycle_no;
  int                             idle_run;
  int                             last_gap;
  bit                             stalled;
  logic [`STREAM_TDATA_WIDTH-1:0] held_data;
  logic [STRB_W-1:0]              held_strb;
  logic                           held_last;

  tb_clock_gen #(
    .CLK_PERIOD_NS (CLK_PERIOD_NS),
    .RESET_CYCLES  (RESET_CYCLES)
  ) tb_clock_gen_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN)
  );

  axis_pattern_source axis_pattern_source_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .enable         (enable),
    .M_AXIS_TVALID  (M_AXIS_TVALID),
    .M_AXIS_TDATA   (M_AXIS_TDATA),
    .M_AXIS_TSTRB   (M_AXIS_TSTRB),
    .M_AXIS_TLAST   (M_AXIS_TLAST),
    .M_AXIS_TREADY  (M_AXIS_TREADY),
    .frame_count    (frame_count)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus table
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic set_row(input int idx, input string name, input int mode, input int pct,
                         input bit drop, input int beats);
    row_name[idx]  = name;
    row_mode[idx]  = mode;
    row_pct[idx]   = pct;
    row_drop[idx]  = drop;
    row_beats[idx] = beats;
  endtask

  // One row per frame: name, TREADY mode, TREADY percentage, enable drop, beats.
  task automatic fill_table;
    set_row(0, "ready_always",    READY_ALWAYS,    100, 1'b0, `BURST_WORDS);
    set_row(1, "ready_alternate", READY_ALTERNATE, 50,  1'b0, `BURST_WORDS);
    set_row(2, "ready_random_50", READY_RANDOM,    50,  1'b0, `BURST_WORDS);
    set_row(3, "ready_random_20", READY_RANDOM,    20,  1'b0, `BURST_WORDS);
    set_row(4, "enable_drop",     READY_RANDOM,    60,  1'b1, `BURST_WORDS);
    set_row(5, "enable_restored", READY_ALWAYS,    100, 1'b0, `BURST_WORDS);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  function automatic logic pick_ready(input int r);
    case (row_mode[r])
      READY_ALWAYS:    return 1'b1;
      READY_ALTERNATE: return cycle_no[0];
      default:         return ($urandom_range(99, 0) < row_pct[r]);
    endcase
  endfunction

  // Outputs are stable at the falling edge, so the handshake of the
  // coming rising edge is already known once TREADY is chosen here.
  task automatic step_cycle(input int r, output bit taken);
    logic ready;
    @(negedge M_AXIS_ACLK);
    cycle_no++;
    if (stalled) begin
      check_value({row_name[r], " held TVALID"}, 1, M_AXIS_TVALID);
      check_value({row_name[r], " held TDATA"}, held_data, M_AXIS_TDATA);
      check_value({row_name[r], " held TSTRB"}, held_strb, M_AXIS_TSTRB);
      check_value({row_name[r], " held TLAST"}, held_last, M_AXIS_TLAST);
    end
    if (M_AXIS_TVALID) begin
      if (idle_run > 0) begin
        last_gap = idle_run;
      end
      idle_run = 0;
    end else begin
      idle_run++;
    end
    ready         = pick_ready(r);
    M_AXIS_TREADY = ready;
    taken         = M_AXIS_TVALID && ready;
    stalled       = M_AXIS_TVALID && !ready;
    held_data     = M_AXIS_TDATA;
    held_strb     = M_AXIS_TSTRB;
    held_last     = M_AXIS_TLAST;
  endtask

  task automatic expect_quiet(input string name, input int r, input int frames,
                              input int cycles);
    bit taken;
    repeat (cycles) begin
      step_cycle(r, taken);
      check_value({name, " TVALID low"}, 0, M_AXIS_TVALID);
      check_value({name, " TLAST low"}, 0, M_AXIS_TLAST);
      check_value({name, " frame_count"}, frames, frame_count);
    end
  endtask

  task automatic run_frame(input int r);
    int                             waited;
    int                             accepted;
    bit                             taken;
    bit                             seen_last;
    logic [`STREAM_TDATA_WIDTH-1:0] exp_data;
    waited    = 0;
    accepted  = 0;
    seen_last = 1'b0;
    enable    = 1'b1;
    do begin
      step_cycle(r, taken);
      waited++;
      if (!M_AXIS_TVALID) begin
        check_value({row_name[r], " TLAST while idle"}, 0, M_AXIS_TLAST);
        check_value({row_name[r], " frame_count while idle"}, r, frame_count);
      end
    end while (!M_AXIS_TVALID);
    if (r == 0) begin
      check_value({row_name[r], " first TVALID not early"}, 1,
                  waited >= `STREAM_START_COUNT + 2);
    end else begin
      check_value({row_name[r], " idle gap long enough"}, 1,
                  last_gap >= `STREAM_START_COUNT);
    end
    check_value({row_name[r], " frame_count"}, r, frame_count);
    // One beat past the expected count is allowed so a missing TLAST shows up.
    while (!seen_last && accepted <= row_beats[r]) begin
      if (taken) begin
        exp_data = {HALF_W'(r), HALF_W'(accepted + 1)};
        check_value({row_name[r], " TDATA"}, exp_data, M_AXIS_TDATA);
        check_value({row_name[r], " TSTRB"}, {STRB_W{1'b1}}, M_AXIS_TSTRB);
        check_value({row_name[r], " TLAST"}, (accepted + 1 == `BURST_WORDS), M_AXIS_TLAST);
        seen_last = M_AXIS_TLAST;
        accepted++;
        if (row_drop[r] && accepted == 1) begin
          enable = 1'b0;
        end
      end
      if (!seen_last) begin
        step_cycle(r, taken);
      end
    end
    check_value({row_name[r], " beat count"}, row_beats[r], accepted);
    step_cycle(r, taken);
    check_value({row_name[r], " frame_count after burst"}, r + 1, frame_count);
    check_value({row_name[r], " TVALID after burst"}, 0, M_AXIS_TVALID);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    check_count   = 0;
    error_count   = 0;
    cycle_no      = 0;
    idle_run      = 0;
    last_gap      = 0;
    stalled       = 1'b0;
    enable        = 1'b0;
    M_AXIS_TREADY = 1'b0;
    void'($urandom(56));
    fill_table();
    // Sampling starts once the first rising edge has applied the reset.
    @(posedge M_AXIS_ACLK);
    expect_quiet("reset_state", 0, 0, RESET_CYCLES - 1);
    wait (M_AXIS_ARESETN === 1'b1);
    expect_quiet("enable_low", 0, 0, QUIET_CYCLES);
    for (int r = 0; r < N_ROWS; r++) begin
      run_frame(r);
      if (row_drop[r]) begin
        // No new burst may start while enable stays low.
        expect_quiet(row_name[r], r, r + 1, QUIET_CYCLES);
      end
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired after %0d cycles, the stream stopped making progress",
             WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- files.f
+incdir+verilog
verilog/axis_source_pkg.sv
verilog/burst_sequencer.sv
verilog/burst_emitter.sv
verilog/axis_pattern_source.sv
testbench/tb_clock_gen.sv
testbench/tb_axis_pattern_source.sv

//--- Bender.yml
package:
  name: axis_pattern_source

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axis_source_pkg.sv
      - verilog/burst_sequencer.sv
      - verilog/burst_emitter.sv
      - verilog/axis_pattern_source.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_axis_pattern_source.sv
